// ==== exec_pipe.f ====
+incdir+verilog
+incdir+verif
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/exe_stage.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/exec_pipe.sv
verif/exec_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute / memory pipeline testbench

VERILATOR ?= verilator
TOP       ?= exec_pipe_tb
FILE_LIST ?= exec_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/exec_pipe_model.svh ====
//////////////////////////////////////////////////////////////////////
// execute pipeline reference model
// ALU rules, a byte mirror of the low 64 bytes of data RAM and the
// queue of expected write-back results
//////////////////////////////////////////////////////////////////////
`ifndef EXEC_PIPE_MODEL_SVH
`define EXEC_PIPE_MODEL_SVH

localparam int MODEL_BYTES = 64;

logic [7:0]         ref_mem [0:MODEL_BYTES-1];
cpu_pkg::word_t     exp_pc_q[$];
logic               exp_en_q[$];
cpu_pkg::reg_addr_t exp_addr_q[$];
cpu_pkg::word_t     exp_data_q[$];
int                 exp_cycle_q[$];

// one rule per opcode bit
function automatic cpu_pkg::word_t alu_ref(input cpu_pkg::alu_op_t op,
	input cpu_pkg::word_t a, input cpu_pkg::word_t b);
	cpu_pkg::word_t r;
	r = '0;
	if (op[`ALU_ADD])
		r = a + b;
	else if (op[`ALU_SUB])
		r = a - b;
	else if (op[`ALU_SLT])
		r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	else if (op[`ALU_SLTU])
		r = (a < b) ? 32'd1 : 32'd0;
	else if (op[`ALU_AND])
		r = a & b;
	else if (op[`ALU_NOR])
		r = ~(a | b);
	else if (op[`ALU_OR])
		r = a | b;
	else if (op[`ALU_XOR])
		r = a ^ b;
	else if (op[`ALU_SLL])
		r = a << b[4:0];
	else if (op[`ALU_SRL])
		r = a >> b[4:0];
	else if (op[`ALU_SRA])
		r = $signed(a) >>> b[4:0];
	else if (op[`ALU_LUI])
		r = b;
	return r;
endfunction

task automatic model_reset();
	for (int i = 0; i < MODEL_BYTES; i++)
		ref_mem[i] = 8'h00;
	exp_pc_q.delete();
	exp_en_q.delete();
	exp_addr_q.delete();
	exp_data_q.delete();
	exp_cycle_q.delete();
endtask

// called for every accepted instruction, in order
task automatic model_accept(input cpu_pkg::word_t pc, input cpu_pkg::alu_op_t op,
	input cpu_pkg::word_t s1, input cpu_pkg::word_t s2, input cpu_pkg::word_t sdata,
	input cpu_pkg::reg_addr_t waddr, input logic wen, input logic load,
	input logic mem_en, input logic mem_we, input logic byte_f, input int cycle);
	cpu_pkg::word_t res;
	cpu_pkg::word_t wb;
	logic [5:0]     a;
	res = alu_ref(op, s1, s2);
	wb  = res;
	a   = res[5:0];
	if (mem_en && mem_we)
	begin
		if (byte_f)
			ref_mem[a] = sdata[7:0];
		else
			for (int i = 0; i < 4; i++)
				ref_mem[a + 6'(i)] = sdata[8*i +: 8];
	end
	else if (mem_en && load)
	begin
		// little endian, byte loads sign-extended
		if (byte_f)
			wb = {{24{ref_mem[a][7]}}, ref_mem[a]};
		else
			wb = {ref_mem[a + 6'd3], ref_mem[a + 6'd2], ref_mem[a + 6'd1], ref_mem[a]};
	end
	exp_pc_q.push_back(pc);
	exp_en_q.push_back(wen);
	exp_addr_q.push_back(waddr);
	exp_data_q.push_back(wb);
	exp_cycle_q.push_back(cycle);
endtask

`endif

// ==== verif/exec_pipe_tb.sv ====
//////////////////////////////////////////////////////////////////////
// execute pipeline testbench
// random ALU and load / store traffic with back-pressure, checked
// against the reference model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_pipe_tb;

	localparam int N_CLEAR        = 16;
	localparam int N_ALU          = 200;
	localparam int N_MEM          = 200;
	localparam int N_BP           = 300;
	localparam int N_TOTAL        = N_CLEAR + N_ALU + N_MEM + N_BP;
	localparam int TIMEOUT_CYCLES = N_TOTAL * 20 + 100;
	localparam int unsigned RAND_SEED = 32'h2e2f;
	// idle cycles allowed for the pipeline to empty after the last issue
	localparam int DRAIN_CYCLES   = 50;

	logic               clk;
	logic               reset;
	logic               in_valid;
	logic               in_allow_in;
	cpu_pkg::word_t     in_pc;
	cpu_pkg::alu_op_t   in_alu_op;
	cpu_pkg::word_t     in_src1;
	cpu_pkg::word_t     in_src2;
	cpu_pkg::word_t     in_store_data;
	cpu_pkg::reg_addr_t in_rf_w_addr;
	logic               in_rf_w_en;
	logic               in_load;
	logic               in_mem_en;
	logic               in_mem_we;
	logic               in_byte;
	logic               out_allow_in;
	logic               out_valid;
	cpu_pkg::word_t     out_pc;
	logic               out_rf_w_en;
	cpu_pkg::reg_addr_t out_rf_w_addr;
	cpu_pkg::word_t     out_rf_w_data;

	int                 error_count;
	int                 check_count;
	int                 cycle_count;
	logic               have_instr;
	cpu_pkg::word_t     pc_next;

	`include "exec_pipe_model.svh"

	exec_pipe DUT (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_allow_in   (in_allow_in),
		.in_pc         (in_pc),
		.in_alu_op     (in_alu_op),
		.in_src1       (in_src1),
		.in_src2       (in_src2),
		.in_store_data (in_store_data),
		.in_rf_w_addr  (in_rf_w_addr),
		.in_rf_w_en    (in_rf_w_en),
		.in_load       (in_load),
		.in_mem_en     (in_mem_en),
		.in_mem_we     (in_mem_we),
		.in_byte       (in_byte),
		.out_allow_in  (out_allow_in),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.out_rf_w_en   (out_rf_w_en),
		.out_rf_w_addr (out_rf_w_addr),
		.out_rf_w_data (out_rf_w_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_reg_addr(input string name, input cpu_pkg::reg_addr_t exp,
		input cpu_pkg::reg_addr_t act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	// pop the oldest expected result for an output transfer
	task automatic compare_output(input string phase, input logic check_lat);
		cpu_pkg::word_t pc;
		string          tag;
		int             cyc;
		if (exp_pc_q.size() == 0)
		begin
			error_count++;
			$display("%s: output of pc %h with no instruction outstanding", phase, out_pc);
		end
		else
		begin
			pc  = exp_pc_q.pop_front();
			cyc = exp_cycle_q.pop_front();
			tag = $sformatf("%s pc %h", phase, pc);
			check_word({tag, " out_pc"}, pc, out_pc);
			check_bit({tag, " rf_w_en"}, exp_en_q.pop_front(), out_rf_w_en);
			check_reg_addr({tag, " rf_w_addr"}, exp_addr_q.pop_front(), out_rf_w_addr);
			check_word({tag, " rf_w_data"}, exp_data_q.pop_front(), out_rf_w_data);
			// two edges from accept to write-back without stalls
			if (check_lat)
				check_word({tag, " latency"}, cpu_pkg::word_t'(2),
					cpu_pkg::word_t'(cycle_count - cyc));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic drive_alu();
		in_alu_op     = cpu_pkg::alu_op_t'(1) << $urandom_range(0, 11);
		in_src1       = $urandom;
		// equal operands now and then for the compares
		in_src2       = ($urandom_range(0, 3) == 0) ? in_src1 : $urandom;
		in_store_data = $urandom;
		in_rf_w_addr  = cpu_pkg::reg_addr_t'($urandom);
		in_rf_w_en    = 1'($urandom_range(0, 1));
		in_load       = 1'b0;
		in_mem_en     = 1'b0;
		in_mem_we     = 1'b0;
		in_byte       = 1'b0;
	endtask

	// mode 0 word store, 1 byte store, 2 word load, 3 byte load
	task automatic drive_mem(input logic clear, input int idx);
		logic [5:0] addr;
		int         mode;
		mode = clear ? 0 : $urandom_range(0, 3);
		addr = clear ? 6'(idx * 4) : 6'($urandom_range(0, 63));
		if (mode == 0 || mode == 2)
			addr[1:0] = 2'b00;
		in_alu_op     = cpu_pkg::alu_op_t'(1) << `ALU_ADD;
		in_src1       = $urandom;
		in_src2       = cpu_pkg::word_t'(addr) - in_src1;
		in_store_data = clear ? '0 : $urandom;
		in_rf_w_addr  = cpu_pkg::reg_addr_t'($urandom);
		in_mem_en     = 1'b1;
		in_mem_we     = (mode < 2);
		in_load       = (mode >= 2);
		in_rf_w_en    = (mode >= 2);
		in_byte       = (mode == 1 || mode == 3);
	endtask

	// kind 0 RAM clear, 1 ALU, 2 memory, 3 mixed
	task automatic run_phase(input string phase, input int kind, input int count,
		input logic back_pressure);
		int issued;
		int drain;
		issued = 0;
		drain  = 0;
		while ((issued < count || exp_pc_q.size() != 0 || have_instr)
			&& drain < DRAIN_CYCLES)
		begin
			@(negedge clk);
			if (!have_instr && issued < count && (!back_pressure || $urandom_range(0, 3) != 0))
			begin
				in_pc   = pc_next;
				pc_next = pc_next + 32'd4;
				if (kind == 1 || (kind == 3 && $urandom_range(0, 1) == 0))
					drive_alu();
				else
					drive_mem(kind == 0, issued);
				have_instr = 1'b1;
				issued++;
			end
			in_valid     = have_instr;
			out_allow_in = back_pressure ? ($urandom_range(0, 2) != 0) : 1'b1;
			#1;
			// transfers at the coming rising edge
			if (out_valid && out_allow_in)
				compare_output(phase, !back_pressure);
			if (in_valid && in_allow_in)
			begin
				model_accept(in_pc, in_alu_op, in_src1, in_src2, in_store_data, in_rf_w_addr,
					in_rf_w_en, in_load, in_mem_en, in_mem_we, in_byte, cycle_count);
				have_instr = 1'b0;
			end
			// idle cycles once everything has been accepted
			if (issued == count && !have_instr)
				drain++;
			cycle_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog

	initial
	begin
		void'($urandom(RAND_SEED));
		error_count   = 0;
		check_count   = 0;
		cycle_count   = 0;
		have_instr    = 1'b0;
		pc_next       = 32'h0000_1000;
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_pc         = '0;
		in_alu_op     = '0;
		in_src1       = '0;
		in_src2       = '0;
		in_store_data = '0;
		in_rf_w_addr  = '0;
		in_rf_w_en    = 1'b0;
		in_load       = 1'b0;
		in_mem_en     = 1'b0;
		in_mem_we     = 1'b0;
		in_byte       = 1'b0;
		out_allow_in  = 1'b1;
		model_reset();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_bit("reset out_valid", 1'b0, out_valid);
		check_bit("reset in_allow_in", 1'b1, in_allow_in);
		run_phase("clear", 0, N_CLEAR, 1'b0);
		run_phase("alu", 1, N_ALU, 1'b0);
		run_phase("memory", 2, N_MEM, 1'b0);
		run_phase("back-pressure", 3, N_BP, 1'b1);
		if (exp_pc_q.size() != 0)
		begin
			error_count++;
			$display("%0d accepted instructions never reached write-back", exp_pc_q.size());
		end
		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: pipeline made no progress within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog/exec_pipe.sv ====
//////////////////////////////////////////////////////////////////////
// execute / memory pipeline top
// execute stage, data RAM and memory stage joined by valid /
// allow-in handshakes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exec_pipe (
	input  logic               clk,
	input  logic               reset,
	// decoded instruction in
	input  logic               in_valid,
	output logic               in_allow_in,
	input  cpu_pkg::word_t     in_pc,
	input  cpu_pkg::alu_op_t   in_alu_op,
	input  cpu_pkg::word_t     in_src1,
	input  cpu_pkg::word_t     in_src2,
	input  cpu_pkg::word_t     in_store_data,
	input  cpu_pkg::reg_addr_t in_rf_w_addr,
	input  logic               in_rf_w_en,
	input  logic               in_load,
	input  logic               in_mem_en,
	input  logic               in_mem_we,
	input  logic               in_byte,
	// write-back out
	input  logic               out_allow_in,
	output logic               out_valid,
	output cpu_pkg::word_t     out_pc,
	output logic               out_rf_w_en,
	output cpu_pkg::reg_addr_t out_rf_w_addr,
	output cpu_pkg::word_t     out_rf_w_data
);

	// execute to memory
	logic               exe_valid;
	logic               mem_allow_in;
	cpu_pkg::word_t     exe_pc;
	cpu_pkg::word_t     exe_result;
	cpu_pkg::reg_addr_t exe_rf_w_addr;
	logic               exe_rf_w_en;
	logic               exe_load;
	logic               exe_byte;

	// data RAM port
	logic               ram_en;
	cpu_pkg::word_t     ram_addr;
	cpu_pkg::byte_en_t  ram_we;
	cpu_pkg::word_t     ram_w_data;
	cpu_pkg::word_t     ram_r_data;

	exe_stage u_exe_stage (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_allow_in   (in_allow_in),
		.in_pc         (in_pc),
		.in_alu_op     (in_alu_op),
		.in_src1       (in_src1),
		.in_src2       (in_src2),
		.in_store_data (in_store_data),
		.in_rf_w_addr  (in_rf_w_addr),
		.in_rf_w_en    (in_rf_w_en),
		.in_load       (in_load),
		.in_mem_en     (in_mem_en),
		.in_mem_we     (in_mem_we),
		.in_byte       (in_byte),
		.mem_allow_in  (mem_allow_in),
		.exe_valid     (exe_valid),
		.exe_pc        (exe_pc),
		.exe_result    (exe_result),
		.exe_rf_w_addr (exe_rf_w_addr),
		.exe_rf_w_en   (exe_rf_w_en),
		.exe_load      (exe_load),
		.exe_byte      (exe_byte),
		.ram_en        (ram_en),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.ram_w_data    (ram_w_data)
	);

	data_ram u_data_ram (
		.clk    (clk),
		.en     (ram_en),
		.addr   (ram_addr),
		.we     (ram_we),
		.w_data (ram_w_data),
		.r_data (ram_r_data)
	);

	mem_stage u_mem_stage (
		.clk           (clk),
		.reset         (reset),
		.exe_valid     (exe_valid),
		.mem_allow_in  (mem_allow_in),
		.exe_pc        (exe_pc),
		.exe_result    (exe_result),
		.exe_rf_w_addr (exe_rf_w_addr),
		.exe_rf_w_en   (exe_rf_w_en),
		.exe_load      (exe_load),
		.exe_byte      (exe_byte),
		.ram_r_data    (ram_r_data),
		.out_allow_in  (out_allow_in),
		.out_valid     (out_valid),
		.out_pc        (out_pc),
		.out_rf_w_en   (out_rf_w_en),
		.out_rf_w_addr (out_rf_w_addr),
		.out_rf_w_data (out_rf_w_data)
	);

endmodule

// ==== verilog/mem_stage.sv ====
//////////////////////////////////////////////////////////////////////
// memory stage
// pipeline register and valid control, load byte extraction with
// sign extension, and write-back data select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mem_stage (
	input  logic               clk,
	input  logic               reset,
	// from execute stage
	input  logic               exe_valid,
	output logic               mem_allow_in,
	input  cpu_pkg::word_t     exe_pc,
	input  cpu_pkg::word_t     exe_result,
	input  cpu_pkg::reg_addr_t exe_rf_w_addr,
	input  logic               exe_rf_w_en,
	input  logic               exe_load,
	input  logic               exe_byte,
	// registered read word from the data RAM
	input  cpu_pkg::word_t     ram_r_data,
	// write-back output
	input  logic               out_allow_in,
	output logic               out_valid,
	output cpu_pkg::word_t     out_pc,
	output logic               out_rf_w_en,
	output cpu_pkg::reg_addr_t out_rf_w_addr,
	output cpu_pkg::word_t     out_rf_w_data
);

	logic           stage_valid;
	cpu_pkg::word_t result_r;
	logic           load_r;
	logic           byte_r;
	logic [7:0]     load_byte;
	cpu_pkg::word_t load_data;

	//////////////////////////////////////////////////////////////////////
	// valid / allow-in control

	assign mem_allow_in = ~stage_valid | out_allow_in;
	assign out_valid    = stage_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			stage_valid <= 1'b0;
		else if (mem_allow_in)
			stage_valid <= exe_valid;
	end

	always_ff @(posedge clk)
	begin
		if (exe_valid && mem_allow_in)
		begin
			out_pc        <= exe_pc;
			result_r      <= exe_result;
			out_rf_w_addr <= exe_rf_w_addr;
			out_rf_w_en   <= exe_rf_w_en;
			load_r        <= exe_load;
			byte_r        <= exe_byte;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// load data and write-back select

	// lane picked by the low address bits
	always_comb
	begin
		case (result_r[1:0])
			2'b00:   load_byte = ram_r_data[7:0];
			2'b01:   load_byte = ram_r_data[15:8];
			2'b10:   load_byte = ram_r_data[23:16];
			default: load_byte = ram_r_data[31:24];
		endcase
	end

	assign load_data = byte_r ? {{(`CPU_XLEN-8){load_byte[7]}}, load_byte} : ram_r_data;

	// non-loads write back the ALU result
	assign out_rf_w_data = load_r ? load_data : result_r;

endmodule

// ==== verilog/data_ram.sv ====
//////////////////////////////////////////////////////////////////////
// data RAM
// single-port word memory with byte write enables and a registered
// read that holds until the next enable
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_consts.svh"

module data_ram (
	input  logic              clk,
	input  logic              en,
	input  cpu_pkg::word_t    addr,
	input  cpu_pkg::byte_en_t we,
	input  cpu_pkg::word_t    w_data,
	output cpu_pkg::word_t    r_data
);

	localparam int DEPTH = 1 << `DATA_RAM_ADDR_W;

	cpu_pkg::word_t              mem [0:DEPTH-1];
	logic [`DATA_RAM_ADDR_W-1:0] word_addr;

	// byte address to word index
	assign word_addr = addr[`DATA_RAM_ADDR_W+1:2];

	//////////////////////////////////////////////////////////////////////
	// write enabled lanes, read old contents

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			for (int i = 0; i < `CPU_XLEN/8; i++)
			begin
				if (we[i])
					mem[word_addr][8*i +: 8] <= w_data[8*i +: 8];
			end
			r_data <= mem[word_addr];
		end
	end

endmodule

// ==== verilog/exe_stage.sv ====
//////////////////////////////////////////////////////////////////////
// execute stage
// pipeline register and valid control, ALU, and data RAM request
// generation for loads and stores
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exe_stage (
	input  logic               clk,
	input  logic               reset,
	// from decode
	input  logic               in_valid,
	output logic               in_allow_in,
	input  cpu_pkg::word_t     in_pc,
	input  cpu_pkg::alu_op_t   in_alu_op,
	input  cpu_pkg::word_t     in_src1,
	input  cpu_pkg::word_t     in_src2,
	input  cpu_pkg::word_t     in_store_data,
	input  cpu_pkg::reg_addr_t in_rf_w_addr,
	input  logic               in_rf_w_en,
	input  logic               in_load,
	input  logic               in_mem_en,
	input  logic               in_mem_we,
	input  logic               in_byte,
	// to memory stage
	input  logic               mem_allow_in,
	output logic               exe_valid,
	output cpu_pkg::word_t     exe_pc,
	output cpu_pkg::word_t     exe_result,
	output cpu_pkg::reg_addr_t exe_rf_w_addr,
	output logic               exe_rf_w_en,
	output logic               exe_load,
	output logic               exe_byte,
	// data RAM request
	output logic               ram_en,
	output cpu_pkg::word_t     ram_addr,
	output cpu_pkg::byte_en_t  ram_we,
	output cpu_pkg::word_t     ram_w_data
);

	logic               stage_valid;
	cpu_pkg::alu_op_t   alu_op_r;
	cpu_pkg::word_t     src1_r;
	cpu_pkg::word_t     src2_r;
	cpu_pkg::word_t     store_data_r;
	logic               mem_en_r;
	logic               mem_we_r;
	cpu_pkg::byte_en_t  byte_lane;

	//////////////////////////////////////////////////////////////////////
	// valid / allow-in control

	// every operation finishes in one cycle
	assign in_allow_in = ~stage_valid | mem_allow_in;
	assign exe_valid   = stage_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			stage_valid <= 1'b0;
		else if (in_allow_in)
			stage_valid <= in_valid;
	end

	// payload capture on a transfer
	always_ff @(posedge clk)
	begin
		if (in_valid && in_allow_in)
		begin
			exe_pc        <= in_pc;
			alu_op_r      <= in_alu_op;
			src1_r        <= in_src1;
			src2_r        <= in_src2;
			store_data_r  <= in_store_data;
			exe_rf_w_addr <= in_rf_w_addr;
			exe_rf_w_en   <= in_rf_w_en;
			exe_load      <= in_load;
			mem_en_r      <= in_mem_en;
			mem_we_r      <= in_mem_we;
			exe_byte      <= in_byte;
		end
	end

	alu u_alu (
		.alu_op (alu_op_r),
		.src1   (src1_r),
		.src2   (src2_r),
		.result (exe_result)
	);

	//////////////////////////////////////////////////////////////////////
	// data RAM request

	// one lane from the low address bits
	always_comb
	begin
		case (exe_result[1:0])
			2'b00:   byte_lane = 4'b0001;
			2'b01:   byte_lane = 4'b0010;
			2'b10:   byte_lane = 4'b0100;
			default: byte_lane = 4'b1000;
		endcase
	end

	// issue only in the cycle the instruction moves on
	assign ram_en     = exe_valid & mem_en_r & mem_allow_in;
	assign ram_addr   = exe_result;
	assign ram_we     = !mem_we_r ? 4'b0000 : (exe_byte ? byte_lane : 4'b1111);
	assign ram_w_data = exe_byte ? {4{store_data_r[7:0]}} : store_data_r;

endmodule

// ==== verilog/alu.sv ====
//////////////////////////////////////////////////////////////////////
// alu
// combinational twelve-operation ALU driven by a one-hot opcode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::word_t   src1,
	input  cpu_pkg::word_t   src2,
	output cpu_pkg::word_t   result
);

	// shared adder for add, sub and the compares
	logic           adder_sub;
	cpu_pkg::word_t adder_b;
	cpu_pkg::word_t adder_sum;
	logic           adder_cout;

	cpu_pkg::word_t slt_res;
	cpu_pkg::word_t sltu_res;
	cpu_pkg::word_t sll_res;
	cpu_pkg::word_t srl_res;
	cpu_pkg::word_t sra_res;

	assign adder_sub = alu_op[`ALU_SUB] | alu_op[`ALU_SLT] | alu_op[`ALU_SLTU];
	assign adder_b   = adder_sub ? ~src2 : src2;
	assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
		+ {{`CPU_XLEN{1'b0}}, adder_sub};

	// signed less-than from the sign bits and the difference
	assign slt_res  = {{(`CPU_XLEN-1){1'b0}},
		(src1[`CPU_XLEN-1] & ~src2[`CPU_XLEN-1])
		| (~(src1[`CPU_XLEN-1] ^ src2[`CPU_XLEN-1]) & adder_sum[`CPU_XLEN-1])};
	// borrow out means src1 < src2
	assign sltu_res = {{(`CPU_XLEN-1){1'b0}}, ~adder_cout};

	// shift amount is the low five bits
	assign sll_res = src1 << src2[4:0];
	assign srl_res = src1 >> src2[4:0];
	assign sra_res = $signed(src1) >>> src2[4:0];

	//////////////////////////////////////////////////////////////////////
	// one-hot result select

	assign result = ({`CPU_XLEN{alu_op[`ALU_ADD] | alu_op[`ALU_SUB]}} & adder_sum)
		| ({`CPU_XLEN{alu_op[`ALU_SLT]}}  & slt_res)
		| ({`CPU_XLEN{alu_op[`ALU_SLTU]}} & sltu_res)
		| ({`CPU_XLEN{alu_op[`ALU_AND]}}  & (src1 & src2))
		| ({`CPU_XLEN{alu_op[`ALU_NOR]}}  & ~(src1 | src2))
		| ({`CPU_XLEN{alu_op[`ALU_OR]}}   & (src1 | src2))
		| ({`CPU_XLEN{alu_op[`ALU_XOR]}}  & (src1 ^ src2))
		| ({`CPU_XLEN{alu_op[`ALU_SLL]}}  & sll_res)
		| ({`CPU_XLEN{alu_op[`ALU_SRL]}}  & srl_res)
		| ({`CPU_XLEN{alu_op[`ALU_SRA]}}  & sra_res)
		| ({`CPU_XLEN{alu_op[`ALU_LUI]}}  & src2);

endmodule

// ==== verilog/cpu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// cpu package
// data types shared by the pipeline stages and the data RAM
//////////////////////////////////////////////////////////////////////
`include "cpu_consts.svh"

package cpu_pkg;

	// data or address word
	typedef logic [`CPU_XLEN-1:0] word_t;

	// register file index
	typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

	// one-hot ALU operation, bit positions in cpu_consts.svh
	typedef logic [`CPU_ALU_OP_W-1:0] alu_op_t;

	// one enable per byte lane of a word
	typedef logic [`CPU_XLEN/8-1:0] byte_en_t;

endpackage

// ==== verilog/cpu_consts.svh ====
//////////////////////////////////////////////////////////////////////
// cpu constants
// widths, data RAM depth and ALU one-hot opcode bit positions shared
// by the execute and memory stages
//////////////////////////////////////////////////////////////////////
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and register file widths
`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_ALU_OP_W    12

// data RAM depth in words, as log2
`define DATA_RAM_ADDR_W 10

// ALU one-hot opcode bits
`define ALU_ADD         0
`define ALU_SUB         1
`define ALU_SLT         2
`define ALU_SLTU        3
`define ALU_AND         4
`define ALU_NOR         5
`define ALU_OR          6
`define ALU_XOR         7
`define ALU_SLL         8
`define ALU_SRL         9
`define ALU_SRA         10
`define ALU_LUI         11

`endif
